// ==== lcd_pkg.sv ====
package lcd_pkg;

	// clock cycles per microsecond
	localparam int unsigned clks_per_us = 1;

	// panel delays in microseconds
	localparam int unsigned pwrup_us = 500;
	localparam int unsigned init_step_us = 10; // e-high time of each init command
	localparam int unsigned init_wait_us [4] = '{50, 50, 200, 100};
	localparam int unsigned write_us = 50; // full single-write cycle
	localparam int unsigned e_lead_us = 1; // bus setup before e rises
	localparam int unsigned e_high_us = 13;

	// the same delays in clock cycles
	localparam int unsigned pwrup_cyc = pwrup_us * clks_per_us;
	localparam int unsigned init_step_cyc = init_step_us * clks_per_us;
	localparam int unsigned init_cyc = (4 * init_step_us + init_wait_us[0] + init_wait_us[1] +
		init_wait_us[2] + init_wait_us[3]) * clks_per_us;
	localparam int unsigned write_cyc = write_us * clks_per_us;
	localparam int unsigned e_lead_cyc = e_lead_us * clks_per_us;
	localparam int unsigned e_high_cyc = e_high_us * clks_per_us;

	localparam int cnt_bits = $clog2(pwrup_cyc > init_cyc ? pwrup_cyc : init_cyc);

	typedef struct packed {
		logic lines;   // 2-line mode
		logic font;    // 5x10 dots
		logic display;
		logic cursor;
		logic blink;
		logic inc;     // address moves up after each char
		logic shift;   // display shifts with each char
	} lcd_cfg_t;

	localparam logic [7:0] cmd_func_set = 8'h30; // 8-bit bus
	localparam logic [7:0] cmd_disp_ctrl = 8'h08;
	localparam logic [7:0] cmd_clear = 8'h01;
	localparam logic [7:0] cmd_entry_mode = 8'h04;
	localparam logic [7:0] cmd_line1_addr = 8'h80; // ddram 0x00
	localparam logic [7:0] cmd_line2_addr = 8'hC0; // ddram 0x40

	localparam int unsigned line_len = 16;
	localparam int unsigned buf_depth = 32;
	localparam int buf_addr_bits = 5;
	localparam logic [7:0] char_space = 8'h20;

endpackage

// ==== lcd_req_if.sv ====
`timescale 1ns/1ps

// write requests into the panel controller
interface lcd_req_if;
	logic       valid; // one-cycle strobe, only while busy is low
	logic       rs;    // 0 command, 1 character
	logic       rw;
	logic [7:0] data;
	logic       busy;  // high during init and every write cycle

	modport host (
		output valid,
		output rs,
		output rw,
		output data,
		input  busy
	);

	modport dev (
		input  valid,
		input  rs,
		input  rw,
		input  data,
		output busy
	);

endinterface

// ==== lcd_line_buf.sv ====
`timescale 1ns/1ps

module lcd_line_buf (
	input  logic                              clk,
	input  logic                              wr_en,
	input  logic [lcd_pkg::buf_addr_bits-1:0] wr_addr,
	input  logic [7:0]                        wr_char,
	input  logic [lcd_pkg::buf_addr_bits-1:0] rd_addr,
	output logic [7:0]                        rd_char
);
	import lcd_pkg::*;

	logic [7:0] mem [buf_depth];

	// blank text until the host writes
	initial begin
		for (int unsigned i = 0; i < buf_depth; i++) begin
			mem[i] = char_space;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_char;
		end
		rd_char <= mem[rd_addr]; // same-address write shows up one cycle later
	end

endmodule

// ==== lcd_ctrl.sv ====
`timescale 1ns/1ps

module lcd_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  lcd_pkg::lcd_cfg_t cfg,
	lcd_req_if.dev            req,
	output logic              e,
	output logic              rs,
	output logic              rw,
	output logic [7:0]        lcd_data,
	output logic              init_done
);
	import lcd_pkg::*;

	typedef enum logic [1:0] {
		st_pwrup,
		st_init,
		st_idle,
		st_write
	} state_t;

	state_t state;
	logic [cnt_bits-1:0] cnt;
	logic [cnt_bits-1:0] cnt_nxt;
	logic [cnt_bits-1:0] init_cnt_nxt; // init count seen in the next cycle
	logic [7:0] init_w_nxt;
	logic init_e_nxt;
	logic wr_e_nxt;
	logic busy;

	assign cnt_nxt = cnt + cnt_bits'(1);
	assign init_cnt_nxt = (state == st_init) ? cnt_nxt : '0; // pwrup hands over at count 0
	assign req.busy = busy;

	// e high from e_lead_cyc for e_high_cyc cycles of the write
	assign wr_e_nxt = (32'(cnt_nxt) >= e_lead_cyc) && (32'(cnt_nxt) < e_lead_cyc + e_high_cyc);

	// command and e level of the four init steps, bus is zero between pulses
	always_comb begin : init_decode
		int unsigned c;
		int unsigned base;
		c = 32'(init_cnt_nxt);
		base = 0;
		init_e_nxt = 1'b0;
		init_w_nxt = 8'h00;
		for (int unsigned k = 0; k < 4; k++) begin
			if (c >= base && c < base + init_step_cyc) begin
				init_e_nxt = 1'b1;
				case (k)
					0: init_w_nxt = cmd_func_set | {4'b0000, cfg.lines, cfg.font, 2'b00};
					1: init_w_nxt = cmd_disp_ctrl | {5'b00000, cfg.display, cfg.cursor, cfg.blink};
					2: init_w_nxt = cmd_clear;
					default: init_w_nxt = cmd_entry_mode | {6'b000000, cfg.inc, cfg.shift};
				endcase
			end
			base = base + init_step_cyc + init_wait_us[k] * clks_per_us;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_pwrup;
			cnt <= '0;
			busy <= 1'b1;
			init_done <= 1'b0;
			e <= 1'b0;
			rs <= 1'b0;
			rw <= 1'b0;
			lcd_data <= 8'h00;
		end else begin
			case (state)
				st_pwrup: begin
					if (cnt == cnt_bits'(pwrup_cyc - 1)) begin
						state <= st_init;
						cnt <= '0;
						e <= init_e_nxt; // function set pulse starts right away
						lcd_data <= init_w_nxt;
					end else begin
						cnt <= cnt_nxt;
					end
				end
				st_init: begin
					if (cnt == cnt_bits'(init_cyc - 1)) begin
						state <= st_idle;
						cnt <= '0;
						busy <= 1'b0;
						init_done <= 1'b1;
						e <= 1'b0;
						lcd_data <= 8'h00;
					end else begin
						cnt <= init_cnt_nxt;
						e <= init_e_nxt;
						lcd_data <= init_w_nxt;
					end
				end
				st_idle: begin
					if (req.valid) begin
						state <= st_write;
						cnt <= '0;
						busy <= 1'b1;
						rs <= req.rs; // held until the write cycle ends
						rw <= req.rw;
						lcd_data <= req.data;
					end
				end
				default: begin
					if (cnt == cnt_bits'(write_cyc - 1)) begin
						state <= st_idle;
						cnt <= '0;
						busy <= 1'b0;
						e <= 1'b0;
						rs <= 1'b0;
						rw <= 1'b0;
						lcd_data <= 8'h00;
					end else begin
						cnt <= cnt_nxt;
						e <= wr_e_nxt;
					end
				end
			endcase
		end
	end

	// panel latches on the falling edge of e
	a_bus_stable: assert property (@(posedge clk) disable iff (!rst_n)
		e |=> (!e || ($stable(lcd_data) && $stable(rs))));

	// requests only arrive while the controller is free
	a_req_idle: assert property (@(posedge clk) disable iff (!rst_n)
		req.valid |-> !busy);

endmodule

// ==== lcd_text_writer.sv ====
`timescale 1ns/1ps

module lcd_text_writer (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              start,
	input  logic                              init_done,
	output logic [lcd_pkg::buf_addr_bits-1:0] rd_addr,
	input  logic [7:0]                        rd_char,
	lcd_req_if.host                           req,
	output logic                              ready,
	output logic                              done
);
	import lcd_pkg::*;

	typedef enum logic [2:0] {
		ph_idle,
		ph_addr1,
		ph_char,
		ph_addr2,
		ph_finish
	} phase_t;

	phase_t phase;
	logic [buf_addr_bits-1:0] idx; // next character to send
	logic sending;
	logic accept;

	assign sending = (phase == ph_addr1) || (phase == ph_char) || (phase == ph_addr2);
	assign accept = sending && !req.busy; // first cycle the controller is free

	assign req.valid = accept;
	assign req.rs = (phase == ph_char);
	assign req.rw = 1'b0; // writes only

	always_comb begin
		case (phase)
			ph_addr1: req.data = cmd_line1_addr;
			ph_addr2: req.data = cmd_line2_addr;
			default:  req.data = rd_char;
		endcase
	end

	// read runs ahead, the char settles while the previous write is busy
	assign rd_addr = idx;
	assign ready = (phase == ph_idle) && init_done;
	assign done = (phase == ph_finish);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= ph_idle;
			idx <= '0;
		end else begin
			case (phase)
				ph_idle: begin
					if (start && ready) begin // start while not ready is dropped
						phase <= ph_addr1;
						idx <= '0;
					end
				end
				ph_addr1, ph_addr2: begin
					if (accept) begin
						phase <= ph_char;
					end
				end
				ph_char: begin
					if (accept) begin
						idx <= idx + buf_addr_bits'(1); // wraps to 0 after the last char
						if (idx == buf_addr_bits'(line_len - 1)) begin
							phase <= ph_addr2;
						end else if (idx == buf_addr_bits'(buf_depth - 1)) begin
							phase <= ph_finish;
						end
					end
				end
				default: begin
					phase <= ph_idle; // done lasts one cycle
				end
			endcase
		end
	end

	// controller turns busy right after each strobe
	a_valid_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		req.valid |=> req.busy);

endmodule

// ==== lcd_display.sv ====
`timescale 1ns/1ps

module lcd_display (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [6:0]                        init_cfg,
	input  logic                              wr_en,
	input  logic [lcd_pkg::buf_addr_bits-1:0] wr_addr,
	input  logic [7:0]                        wr_char,
	input  logic                              start,
	output logic                              ready,
	output logic                              done,
	output logic                              lcd_e,
	output logic                              lcd_rs,
	output logic                              lcd_rw,
	output logic [7:0]                        lcd_data
);
	import lcd_pkg::*;

	logic [buf_addr_bits-1:0] rd_addr;
	logic [7:0] rd_char;
	logic init_done;

	lcd_req_if u_req ();

	lcd_line_buf u_line_buf (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_char (wr_char),
		.rd_addr (rd_addr),
		.rd_char (rd_char)
	);

	lcd_text_writer u_text_writer (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.init_done (init_done),
		.rd_addr   (rd_addr),
		.rd_char   (rd_char),
		.req       (u_req.host),
		.ready     (ready),
		.done      (done)
	);

	lcd_ctrl u_lcd_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (lcd_cfg_t'(init_cfg)), // bit 6 lines down to bit 0 shift
		.req       (u_req.dev),
		.e         (lcd_e),
		.rs        (lcd_rs),
		.rw        (lcd_rw),
		.lcd_data  (lcd_data),
		.init_done (init_done)
	);

endmodule

// ==== tb_lcd_display.sv ====
`timescale 1ns/1ps

module tb_lcd_display;
	import lcd_pkg::*;

	typedef struct {
		logic       rs;
		logic [7:0] data;
		int         width; // e-high cycles
		int         gap;   // cycles since previous rise, 0 skips the check
	} exp_wr_t;

	logic clk;
	logic rst_n;
	logic [6:0] init_cfg;
	logic wr_en;
	logic [buf_addr_bits-1:0] wr_addr;
	logic [7:0] wr_char;
	logic start;
	logic ready;
	logic done;
	logic lcd_e;
	logic lcd_rs;
	logic lcd_rw;
	logic [7:0] lcd_data;
	logic rst_q; // reset as seen by the DUT flops

	exp_wr_t exp_q [$];
	logic [7:0] shadow [buf_depth]; // expected buffer content
	int errors = 0;
	bit timed_out = 1'b0;
	int cyc = 0;
	int last_rise = 0;
	int cur_width = 0;
	bit in_pulse = 1'b0;
	logic e_prev = 1'b0;
	int done_cnt = 0;
	int width_cnt = 0;
	int gap_cnt = 0;

	lcd_display u_lcd_display (
		.clk      (clk),
		.rst_n    (rst_n),
		.init_cfg (init_cfg),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_char  (wr_char),
		.start    (start),
		.ready    (ready),
		.done     (done),
		.lcd_e    (lcd_e),
		.lcd_rs   (lcd_rs),
		.lcd_rw   (lcd_rw),
		.lcd_data (lcd_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) rst_q <= rst_n;

	// pin monitor, one record per rising edge of e
	always @(negedge clk) begin : pin_monitor
		exp_wr_t x;
		cyc++;
		if (!rst_q) begin
			in_pulse = 1'b0; // a cut pulse is dropped
			e_prev = 1'b0;
		end else begin
			if (lcd_e && !e_prev) begin
				cur_width = 0;
				if (exp_q.size() == 0) begin
					$display("unexpected panel write rs=%0b data=0x%02h", lcd_rs, lcd_data);
					errors++;
				end else begin
					x = exp_q.pop_front();
					if (lcd_rs !== x.rs) begin
						$display("error lcd_rs: got 0x%0h, expected 0x%0h", lcd_rs, x.rs);
						errors++;
					end
					if (lcd_rw !== 1'b0) begin
						$display("error lcd_rw: got 0x%0h, expected 0x0", lcd_rw);
						errors++;
					end
					if (lcd_data !== x.data) begin
						$display("error lcd_data: got 0x%02h, expected 0x%02h", lcd_data, x.data);
						errors++;
					end
					if (x.gap != 0) begin
						gap_cnt++;
						if (cyc - last_rise != x.gap) begin
							$display("e pulse started %0d cycles after the previous one, expected %0d",
								cyc - last_rise, x.gap);
							errors++;
						end
					end
					cur_width = x.width;
				end
				last_rise = cyc;
				in_pulse = 1'b1;
			end
			if (!lcd_e && e_prev && in_pulse) begin
				if (cur_width != 0) begin
					width_cnt++;
					if (cyc - last_rise != cur_width) begin
						$display("e stayed high for %0d cycles, expected %0d", cyc - last_rise, cur_width);
						errors++;
					end
				end
				in_pulse = 1'b0;
			end
			if (done) done_cnt++;
			e_prev = lcd_e;
		end
	end

	task automatic push_wr(input logic rs, input logic [7:0] data, input int width, input int gap);
		exp_wr_t x;
		x.rs = rs;
		x.data = data;
		x.width = width;
		x.gap = gap;
		exp_q.push_back(x);
	endtask

	// four init commands, 10-cycle pulses, spacing is pulse plus its wait
	task automatic push_init(input logic [6:0] cfg);
		push_wr(1'b0, 8'h30 | {4'b0000, cfg[6], cfg[5], 2'b00}, 10 * clks_per_us, 0);
		push_wr(1'b0, 8'h08 | {5'b00000, cfg[4:2]}, 10 * clks_per_us, 60 * clks_per_us);
		push_wr(1'b0, 8'h01, 10 * clks_per_us, 60 * clks_per_us);
		push_wr(1'b0, 8'h04 | {6'b000000, cfg[1:0]}, 10 * clks_per_us, 210 * clks_per_us);
	endtask

	// first n writes of a frame
	task automatic push_frame(input int n);
		logic rs;
		logic [7:0] d;
		for (int k = 0; k < n; k++) begin
			rs = 1'b1;
			if (k == 0) begin
				rs = 1'b0;
				d = cmd_line1_addr;
			end else if (k == line_len + 1) begin
				rs = 1'b0;
				d = cmd_line2_addr;
			end else if (k <= line_len) begin
				d = shadow[k - 1];
			end else begin
				d = shadow[k - 2];
			end
			push_wr(rs, d, 13 * clks_per_us, (k == 0) ? 0 : 50 * clks_per_us + 1);
		end
	endtask

	task automatic reset_dut(input logic [6:0] cfg);
		@(negedge clk);
		rst_n = 1'b0;
		init_cfg = cfg;
		start = 1'b0;
		wr_en = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic write_buf(input int addr, input logic [7:0] ch);
		@(negedge clk);
		wr_en = 1'b1;
		wr_addr = buf_addr_bits'(addr);
		wr_char = ch;
		shadow[addr] = ch;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic pulse_start();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_writes(input int max_cyc);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < max_cyc) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d expected panel writes never appeared", exp_q.size());
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_ready(input int max_cyc);
		int n;
		n = 0;
		while (ready !== 1'b1 && n < max_cyc) begin
			@(negedge clk);
			n++;
		end
		if (ready !== 1'b1) begin
			$display("timeout: ready never rose after initialization");
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic check_idle_pins();
		if (lcd_e !== 1'b0 || lcd_rs !== 1'b0 || lcd_rw !== 1'b0) begin
			$display("error lcd_e/rs/rw: got 0x%0h, expected 0x0", {lcd_e, lcd_rs, lcd_rw});
			errors++;
		end
		if (lcd_data !== 8'h00) begin
			$display("error lcd_data: got 0x%02h, expected 0x00", lcd_data);
			errors++;
		end
		if (ready !== 1'b0 || done !== 1'b0) begin
			$display("error ready/done: got 0x%0h, expected 0x0", {ready, done});
			errors++;
		end
	endtask

	task automatic test_reset_init();
		logic [6:0] cfg;
		cfg = 7'($urandom);
		push_init(cfg);
		reset_dut(cfg);
		check_idle_pins();
		wait_writes(1200 * clks_per_us);
		wait_ready(200 * clks_per_us);
	endtask

	task automatic test_frame();
		int d0;
		for (int i = 0; i < buf_depth; i++) begin
			write_buf(i, 8'h20 + 8'($urandom % 95)); // printable only
		end
		d0 = done_cnt;
		push_frame(34);
		pulse_start();
		wait_writes(34 * 60 * clks_per_us);
		repeat (60) @(negedge clk);
		if (done_cnt != d0 + 1) begin
			$display("done pulsed %0d times for one frame", done_cnt - d0);
			errors++;
		end
	endtask

	task automatic test_enable_timing();
		int w0;
		int g0;
		w0 = width_cnt;
		g0 = gap_cnt;
		push_frame(34);
		pulse_start();
		wait_writes(34 * 60 * clks_per_us);
		repeat (60) @(negedge clk); // let the last pulse end
		if (width_cnt - w0 != 34 || gap_cnt - g0 != 33) begin
			$display("measured %0d pulse widths and %0d gaps, expected 34 and 33",
				width_cnt - w0, gap_cnt - g0);
			errors++;
		end
	endtask

	task automatic test_ignored_starts();
		logic [6:0] cfg;
		int d0;
		cfg = 7'($urandom);
		push_init(cfg);
		reset_dut(cfg);
		repeat (600 * clks_per_us) @(negedge clk); // inside the init sequence
		d0 = done_cnt;
		pulse_start();
		wait_writes(1200 * clks_per_us);
		wait_ready(200 * clks_per_us);
		repeat (100) @(negedge clk);
		push_frame(34);
		pulse_start();
		repeat (500 * clks_per_us) @(negedge clk);
		pulse_start(); // mid-frame, writer not ready
		wait_writes(34 * 60 * clks_per_us);
		repeat (120) @(negedge clk);
		if (done_cnt != d0 + 1) begin
			$display("done pulsed %0d times, expected once for the accepted start", done_cnt - d0);
			errors++;
		end
	endtask

	task automatic test_rewrite_reset();
		logic [6:0] cfg;
		write_buf(0, 8'h41);
		write_buf(15, 8'h5a);
		write_buf(16, 8'h30);
		write_buf(31, 8'h7e);
		test_frame_only();
		push_frame(6);
		pulse_start();
		wait_writes(10 * 60 * clks_per_us);
		repeat (5) @(negedge clk); // e is high here
		cfg = 7'($urandom);
		reset_dut(cfg);
		check_idle_pins();
		push_init(cfg);
		wait_writes(1200 * clks_per_us);
		wait_ready(200 * clks_per_us);
	endtask

	task automatic test_frame_only();
		push_frame(34);
		pulse_start();
		wait_writes(34 * 60 * clks_per_us);
		repeat (60) @(negedge clk);
	endtask

	initial begin
		void'($urandom(89116));
		rst_n = 1'b0;
		init_cfg = 7'h00;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_char = 8'h00;
		start = 1'b0;
		for (int i = 0; i < buf_depth; i++) begin
			shadow[i] = 8'h20;
		end
		test_reset_init();
		if (!timed_out) test_frame();
		if (!timed_out) test_enable_timing();
		if (!timed_out) test_ignored_starts();
		if (!timed_out) test_rewrite_reset();
		$display("errors: %0d, timeouts: %0d, done pulses: %0d", errors, timed_out, done_cnt);
		if (errors == 0 && !timed_out) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== lcd_display.f ====
lcd_pkg.sv
lcd_req_if.sv
lcd_line_buf.sv
lcd_ctrl.sv
lcd_text_writer.sv
lcd_display.sv
tb_lcd_display.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lcd_display
FLIST     ?= lcd_display.f
MDIR      ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(MDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FLIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)
